// File: Bender.yml
package:
  name: arcade_frame_glue

sources:
  - source/arcade_pkg.sv
  - source/cen_gen.sv
  - source/video_timer.sv
  - source/rom_download.sv
  - source/rom_slot_arbiter.sv
  - source/game_top.sv
  - target: test
    files:
      - verif/game_top_tb.sv

// File: source/arcade_pkg.sv
// Shared widths and types for the arcade frame glue
// SDRAM word views and ROM slot indices

package arcade_pkg;

    localparam int sdram_aw = 22;   // SDRAM word address
    localparam int pos_w    = 9;    // H and V counters

    // ROM slot address widths
    localparam int char_aw = 14;
    localparam int main_aw = 17;
    localparam int obj_aw  = 18;

    localparam int slot_n     = 3;
    localparam int slot_sel_w = $clog2(slot_n);

    typedef logic [slot_sel_w-1:0] slot_idx_t;

    // Fixed priority order, lowest index wins
    localparam slot_idx_t slot_char = 0;
    localparam slot_idx_t slot_main = 1;
    localparam slot_idx_t slot_obj  = 2;

    // One 32-bit SDRAM read, seen as halves or as bytes
    typedef union packed {
        logic [1:0][15:0] halves;   // 16-bit slots use halves[0]
        logic [3:0][7:0]  bytes;    // 8-bit slot picks byte 0 or 1
    } sdram_word_t;

endpackage

// File: source/cen_gen.sv
// Clock enable generator
// 12, 8 and 6 MHz strobes from the 48 MHz clock

`timescale 1ns/1ps

module cen_gen (
    input  logic clk,
    input  logic rst,
    output logic cen12,
    output logic cen8,
    output logic cen6
);

    logic [2:0] cnt;    // Divide by 4 and by 8
    logic [2:0] cnt6;   // Divide by 6

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            cnt6  <= '0;
            cen12 <= 1'b0;
            cen8  <= 1'b0;
            cen6  <= 1'b0;
        end else begin
            cnt   <= cnt + 1'b1;
            cnt6  <= (cnt6 == 3'd5) ? 3'd0 : cnt6 + 1'b1;
            cen12 <= cnt[1:0] == 2'd3;
            cen6  <= cnt == 3'd7;
            cen8  <= cnt6 == 3'd5;  // Not aligned with the other two
        end
    end

endmodule

// File: source/game_top.sv
// Arcade frame glue top level
// Clock enables, video timing, ROM download and cached ROM slots

`timescale 1ns/1ps

module game_top import arcade_pkg::*; #(
    parameter logic [pos_w-1:0]    HCNT_END    = 9'h1FF,
    parameter logic [pos_w-1:0]    HB_START    = 9'h0C7,
    parameter logic [pos_w-1:0]    HB_END      = 9'h147,
    parameter logic [pos_w-1:0]    HS_START    = 9'h0E7,
    parameter logic [pos_w-1:0]    HS_END      = 9'h127,
    parameter logic [pos_w-1:0]    VCNT_END    = 9'h0FF,
    parameter logic [pos_w-1:0]    VB_START    = 9'h0F0,
    parameter logic [pos_w-1:0]    VB_END      = 9'h010,
    parameter logic [pos_w-1:0]    VS_START    = 9'h000,
    parameter logic [pos_w-1:0]    VS_END      = 9'h008,
    parameter logic [sdram_aw-1:0] char_offset = 22'h01_4000,
    parameter logic [sdram_aw-1:0] main_offset = 22'h00_0000,
    parameter logic [sdram_aw-1:0] obj_offset  = 22'h03_6000
) (
    input  logic                rst,
    input  logic                clk,
    // Video
    output logic                pxl2_cen,   // 12 MHz
    output logic                pxl_cen,    // 6 MHz
    output logic                lhbl,
    output logic                lvbl,
    output logic                hs,
    output logic                vs,
    output logic [pos_w-1:0]    h,
    output logic [pos_w-1:0]    v,
    // ROM download
    input  logic                downloading,
    output logic                dwnld_busy,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    output logic [sdram_aw-1:0] prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we,
    // ROM slots
    input  logic                char_cs,
    input  logic [char_aw-1:0]  char_addr,
    output logic                char_ok,
    output logic [15:0]         char_dout,
    input  logic                main_cs,
    input  logic [main_aw-1:0]  main_addr,
    output logic                main_ok,
    output logic [7:0]          main_dout,
    input  logic                obj_cs,
    input  logic [obj_aw-1:0]   obj_addr,
    output logic                obj_ok,
    output logic [15:0]         obj_dout,
    // SDRAM
    output logic                sdram_req,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [31:0]         data_read,
    output logic [sdram_aw-1:0] sdram_addr,
    output logic                refresh_en
);

    logic cen8;     // Pixel clock of the timer

    assign dwnld_busy = downloading;

    cen_gen u_cen (
        .clk   ( clk      ),
        .rst   ( rst      ),
        .cen12 ( pxl2_cen ),
        .cen8  ( cen8     ),
        .cen6  ( pxl_cen  )
    );

    video_timer #(
        .HCNT_END ( HCNT_END ),
        .HB_START ( HB_START ),
        .HB_END   ( HB_END   ),
        .HS_START ( HS_START ),
        .HS_END   ( HS_END   ),
        .VCNT_END ( VCNT_END ),
        .VB_START ( VB_START ),
        .VB_END   ( VB_END   ),
        .VS_START ( VS_START ),
        .VS_END   ( VS_END   )
    ) u_timer (
        .clk     ( clk  ),
        .rst     ( rst  ),
        .pxl_cen ( cen8 ),
        .h       ( h    ),
        .v       ( v    ),
        .lhbl    ( lhbl ),
        .lvbl    ( lvbl ),
        .hs      ( hs   ),
        .vs      ( vs   )
    );

    rom_download u_dwnld (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     )
    );

    rom_slot_arbiter #(
        .char_offset ( char_offset ),
        .main_offset ( main_offset ),
        .obj_offset  ( obj_offset  )
    ) u_rom (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .lvbl        ( lvbl        ),
        .char_cs     ( char_cs     ),
        .char_addr   ( char_addr   ),
        .char_ok     ( char_ok     ),
        .char_dout   ( char_dout   ),
        .main_cs     ( main_cs     ),
        .main_addr   ( main_addr   ),
        .main_ok     ( main_ok     ),
        .main_dout   ( main_dout   ),
        .obj_cs      ( obj_cs      ),
        .obj_addr    ( obj_addr    ),
        .obj_ok      ( obj_ok      ),
        .obj_dout    ( obj_dout    ),
        .sdram_req   ( sdram_req   ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .sdram_addr  ( sdram_addr  ),
        .refresh_en  ( refresh_en  )
    );

endmodule

// File: source/rom_download.sv
// ROM downloader
// Byte writes from the loader become masked 16-bit SDRAM writes

`timescale 1ns/1ps

module rom_download import arcade_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                downloading,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_data,
    input  logic                ioctl_wr,
    input  logic                sdram_ack,
    output logic [sdram_aw-1:0] prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,
    output logic                prog_we
);

    logic accept;

    // New byte only when no write is pending
    assign accept = downloading && ioctl_wr && !prog_we;

    always_ff @(posedge clk) begin
        if (rst)
            prog_we <= 1'b0;
        else if (accept)
            prog_we <= 1'b1;
        else if (sdram_ack)
            prog_we <= 1'b0;    // Controller took the write
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prog_addr <= ioctl_addr[sdram_aw:1];    // Byte to word address
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;   // Active low lane mask
        end
    end

endmodule

// File: source/rom_slot_arbiter.sv
// ROM slot arbiter
// Three single-entry caches share one SDRAM read port with fixed priority

`timescale 1ns/1ps

module rom_slot_arbiter import arcade_pkg::*; #(
    parameter logic [sdram_aw-1:0] char_offset = '0,
    parameter logic [sdram_aw-1:0] main_offset = '0,
    parameter logic [sdram_aw-1:0] obj_offset  = '0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                downloading,
    input  logic                lvbl,
    // Char layer
    input  logic                char_cs,
    input  logic [char_aw-1:0]  char_addr,
    output logic                char_ok,
    output logic [15:0]         char_dout,
    // Main CPU
    input  logic                main_cs,
    input  logic [main_aw-1:0]  main_addr,
    output logic                main_ok,
    output logic [7:0]          main_dout,
    // Object layer
    input  logic                obj_cs,
    input  logic [obj_aw-1:0]   obj_addr,
    output logic                obj_ok,
    output logic [15:0]         obj_dout,
    // SDRAM read port
    output logic                sdram_req,
    input  logic                sdram_ack,
    input  logic                data_rdy,
    input  logic [31:0]         data_read,
    output logic [sdram_aw-1:0] sdram_addr,
    output logic                refresh_en
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_data
    } state_t;

    state_t             state;
    slot_idx_t          sel;    // Slot being fetched
    slot_idx_t          pick;
    sdram_word_t        rd_word;
    logic               issue;
    logic               fill_now;
    logic [slot_n-1:0]  valid;
    logic [slot_n-1:0]  match;
    logic [slot_n-1:0]  need;
    logic [slot_n-1:0]  fill;

    // Cached entries
    logic [char_aw-1:0] char_tag;
    logic [main_aw-1:0] main_tag;
    logic [obj_aw-1:0]  obj_tag;
    logic [15:0]        char_data;
    logic [7:0]         main_data;
    logic [15:0]        obj_data;

    assign rd_word = data_read;

    assign match[slot_char] = char_tag == char_addr;
    assign match[slot_main] = main_tag == main_addr;
    assign match[slot_obj]  = obj_tag == obj_addr;

    // Char fetches only outside vertical blanking
    assign need[slot_char] = char_cs && lvbl && !(valid[slot_char] && match[slot_char]);
    assign need[slot_main] = main_cs && !(valid[slot_main] && match[slot_main]);
    assign need[slot_obj]  = obj_cs && !(valid[slot_obj] && match[slot_obj]);

    always_comb begin
        if (need[slot_char])
            pick = slot_char;
        else if (need[slot_main])
            pick = slot_main;
        else
            pick = slot_obj;
    end

    assign issue    = (state == st_idle) && !downloading && (|need);
    assign fill_now = (state == st_wait_data) && !downloading && data_rdy;

    assign fill[slot_char] = fill_now && (sel == slot_char);
    assign fill[slot_main] = fill_now && (sel == slot_main);
    assign fill[slot_obj]  = fill_now && (sel == slot_obj);

    assign refresh_en = (state == st_idle) && !(|need);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            sel       <= slot_char;
            sdram_req <= 1'b0;
            valid     <= '0;
        end else if (downloading) begin
            state     <= st_idle;   // ROM contents are changing
            sdram_req <= 1'b0;
            valid     <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (issue) begin
                        sel         <= pick;
                        valid[pick] <= 1'b0;
                        sdram_req   <= 1'b1;
                        state       <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= st_wait_data;
                    end
                end
                st_wait_data: begin
                    if (data_rdy) begin
                        valid[sel] <= 1'b1;
                        state      <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Tag and address are taken when the fetch starts
    always_ff @(posedge clk) begin
        if (issue) begin
            case (pick)
                slot_char: begin
                    char_tag   <= char_addr;
                    sdram_addr <= char_offset + sdram_aw'(char_addr);
                end
                slot_main: begin
                    main_tag   <= main_addr;
                    sdram_addr <= main_offset + sdram_aw'(main_addr[main_aw-1:1]);
                end
                default: begin
                    obj_tag    <= obj_addr;
                    sdram_addr <= obj_offset + sdram_aw'(obj_addr);
                end
            endcase
        end
        if (fill[slot_char])
            char_data <= rd_word.halves[0];
        if (fill[slot_main])
            main_data <= rd_word.bytes[{1'b0, main_tag[0]}];
        if (fill[slot_obj])
            obj_data <= rd_word.halves[0];
    end

    // Fill data bypasses the cache so ok follows data_rdy by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            char_ok <= 1'b0;
            main_ok <= 1'b0;
            obj_ok  <= 1'b0;
        end else begin
            char_ok <= char_cs && match[slot_char] && (valid[slot_char] || fill[slot_char]);
            main_ok <= main_cs && match[slot_main] && (valid[slot_main] || fill[slot_main]);
            obj_ok  <= obj_cs && match[slot_obj] && (valid[slot_obj] || fill[slot_obj]);
        end
    end

    always_ff @(posedge clk) begin
        char_dout <= fill[slot_char] ? rd_word.halves[0] : char_data;
        main_dout <= fill[slot_main] ? rd_word.bytes[{1'b0, main_tag[0]}] : main_data;
        obj_dout  <= fill[slot_obj] ? rd_word.halves[0] : obj_data;
    end

endmodule

// File: source/video_timer.sv
// Video timer with pixel and line counters
// Blanking and sync come from comparing the counters with the parameters

`timescale 1ns/1ps

module video_timer import arcade_pkg::*; #(
    parameter logic [pos_w-1:0] HCNT_END = 9'h1FF,
    parameter logic [pos_w-1:0] HB_START = 9'h0C7,
    parameter logic [pos_w-1:0] HB_END   = 9'h147,
    parameter logic [pos_w-1:0] HS_START = 9'h0E7,
    parameter logic [pos_w-1:0] HS_END   = 9'h127,
    parameter logic [pos_w-1:0] VCNT_END = 9'h0FF,
    parameter logic [pos_w-1:0] VB_START = 9'h0F0,
    parameter logic [pos_w-1:0] VB_END   = 9'h010,
    parameter logic [pos_w-1:0] VS_START = 9'h000,
    parameter logic [pos_w-1:0] VS_END   = 9'h008
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,
    output logic [pos_w-1:0] h,
    output logic [pos_w-1:0] v,
    output logic             lhbl,
    output logic             lvbl,
    output logic             hs,
    output logic             vs
);

    logic [pos_w-1:0] h_nxt;
    logic [pos_w-1:0] v_nxt;

    // True inside [s, e), span may wrap past the counter end
    function automatic logic in_span(
        input logic [pos_w-1:0] x,
        input logic [pos_w-1:0] s,
        input logic [pos_w-1:0] e
    );
        if (s <= e)
            return (x >= s) && (x < e);
        else
            return (x >= s) || (x < e);
    endfunction

    always_comb begin
        h_nxt = h + 1'b1;
        v_nxt = v;
        if (h == HCNT_END) begin
            h_nxt = '0;
            v_nxt = (v == VCNT_END) ? '0 : v + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h    <= '0;
            v    <= '0;
            lhbl <= !in_span('0, HB_START, HB_END);
            lvbl <= !in_span('0, VB_START, VB_END);
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (pxl_cen) begin
            h    <= h_nxt;
            v    <= v_nxt;
            lhbl <= !in_span(h_nxt, HB_START, HB_END);
            hs   <= in_span(h_nxt, HS_START, HS_END);
            if (h == HCNT_END) begin    // Line change
                lvbl <= !in_span(v_nxt, VB_START, VB_END);
                vs   <= in_span(v_nxt, VS_START, VS_END);
            end
        end
    end

endmodule

// File: sources.f
source/arcade_pkg.sv
source/cen_gen.sv
source/video_timer.sv
source/rom_download.sv
source/rom_slot_arbiter.sv
source/game_top.sv
verif/game_top_tb.sv

// File: verif/game_top_tb.sv
// Testbench for the arcade frame glue
// Directed tests against an SDRAM model that serves reads and programming writes

`timescale 1ns/1ps

module game_top_tb import arcade_pkg::*; ();

    localparam time clk_period = 100;
    localparam int  cen8_div   = 6;     // Timer pixel enable, one cycle in six

    localparam logic [pos_w-1:0] hcnt_end = 15;
    localparam logic [pos_w-1:0] hb_start = 11;
    localparam logic [pos_w-1:0] hb_end   = 15;
    localparam logic [pos_w-1:0] hs_start = 12;
    localparam logic [pos_w-1:0] hs_end   = 14;
    localparam logic [pos_w-1:0] vcnt_end = 7;
    localparam logic [pos_w-1:0] vb_start = 6;
    localparam logic [pos_w-1:0] vb_end   = 7;
    localparam logic [pos_w-1:0] vs_start = 6;
    localparam logic [pos_w-1:0] vs_end   = 7;

    localparam logic [sdram_aw-1:0] char_off = 22'h00_0400;
    localparam logic [sdram_aw-1:0] main_off = 22'h00_0000;
    localparam logic [sdram_aw-1:0] obj_off  = 22'h00_0800;

    localparam int pixels       = hcnt_end + 1;
    localparam int lines        = vcnt_end + 1;
    localparam int frame_cycles = pixels * lines * cen8_div;
    localparam int wait_limit   = frame_cycles;
    localparam int dwnld_bytes  = 8;
    localparam logic [24:0] dwnld_base = 25'h00_0100;
    localparam int reads_per_slot = 4;

    // Cycle budget of each test
    localparam int reset_len = 4;
    localparam int cen_len   = 50;
    localparam int video_len = frame_cycles + 4;
    localparam int dwnld_len = dwnld_bytes * 10;
    localparam int rom_len   = 3 * reads_per_slot * (frame_cycles / 8 + 20);
    localparam int blank_len = 2 * frame_cycles;
    localparam int prio_len  = 2 * frame_cycles + 40;
    localparam int watchdog_cycles =
        2 * (reset_len + cen_len + video_len + dwnld_len + rom_len + blank_len + prio_len);

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    logic                downloading = 1'b0;
    logic [24:0]         ioctl_addr = '0;
    logic [7:0]          ioctl_data = '0;
    logic                ioctl_wr = 1'b0;
    logic                char_cs = 1'b0;
    logic [char_aw-1:0]  char_addr = '0;
    logic                main_cs = 1'b0;
    logic [main_aw-1:0]  main_addr = '0;
    logic                obj_cs = 1'b0;
    logic [obj_aw-1:0]   obj_addr = '0;
    logic                sdram_ack = 1'b0;
    logic                data_rdy = 1'b0;
    logic [31:0]         data_read = '0;
    logic                pxl2_cen;
    logic                pxl_cen;
    logic                lhbl;
    logic                lvbl;
    logic                hs;
    logic                vs;
    logic [pos_w-1:0]    h;
    logic [pos_w-1:0]    v;
    logic                dwnld_busy;
    logic [sdram_aw-1:0] prog_addr;
    logic [7:0]          prog_data;
    logic [1:0]          prog_mask;
    logic                prog_we;
    logic                char_ok;
    logic [15:0]         char_dout;
    logic                main_ok;
    logic [7:0]          main_dout;
    logic                obj_ok;
    logic [15:0]         obj_dout;
    logic                sdram_req;
    logic [sdram_aw-1:0] sdram_addr;
    logic                refresh_en;

    integer seed = 10;
    int     checks = 0;
    int     errors = 0;
    int     lat_tab [64];   // Read latencies, filled from the seed
    int     req_cnt = 0;
    logic [obj_aw-1:0] last_addr [3] = '{default: '0};

    always #(clk_period / 2) clk = ~clk;

    game_top #(
        .HCNT_END    ( hcnt_end ),
        .HB_START    ( hb_start ),
        .HB_END      ( hb_end   ),
        .HS_START    ( hs_start ),
        .HS_END      ( hs_end   ),
        .VCNT_END    ( vcnt_end ),
        .VB_START    ( vb_start ),
        .VB_END      ( vb_end   ),
        .VS_START    ( vs_start ),
        .VS_END      ( vs_end   ),
        .char_offset ( char_off ),
        .main_offset ( main_off ),
        .obj_offset  ( obj_off  )
    ) game_top_i (.*);

    // SDRAM model
    always begin
        @(posedge clk);
        if (!rst && prog_we) begin
            @(posedge clk);
            sdram_ack <= 1'b1;      // Write taken two cycles later
            @(posedge clk);
            sdram_ack <= 1'b0;
        end else if (!rst && sdram_req) begin
            repeat (lat_tab[req_cnt % 64] - 1) @(posedge clk);
            req_cnt = req_cnt + 1;
            sdram_ack <= 1'b1;
            @(posedge clk);
            sdram_ack <= 1'b0;
            @(posedge clk);
            data_read <= scramble(sdram_addr);
            data_rdy  <= 1'b1;
            @(posedge clk);
            data_rdy  <= 1'b0;
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired before the tests completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Fixed content of the ROM at each word address
    function automatic logic [31:0] scramble(input logic [sdram_aw-1:0] a);
        logic [31:0] x;
        x = a;
        return (x * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
    endfunction

    function automatic string slot_name(input int slot);
        case (slot)
            0:       return "char";
            1:       return "main";
            default: return "obj";
        endcase
    endfunction

    function automatic logic ok_of(input int slot);
        case (slot)
            0:       return char_ok;
            1:       return main_ok;
            default: return obj_ok;
        endcase
    endfunction

    function automatic logic [15:0] dout_of(input int slot);
        case (slot)
            0:       return char_dout;
            1:       return {8'h00, main_dout};
            default: return obj_dout;
        endcase
    endfunction

    // SDRAM word address a slot read must fetch
    function automatic logic [sdram_aw-1:0] req_addr(input int slot,
                                                     input logic [obj_aw-1:0] a);
        logic [sdram_aw-1:0] idx;
        case (slot)
            0:       idx = a[char_aw-1:0];
            1:       idx = a[main_aw-1:1];  // Two bytes per word
            default: idx = a;
        endcase
        case (slot)
            0:       return char_off + idx;
            1:       return main_off + idx;
            default: return obj_off + idx;
        endcase
    endfunction

    function automatic logic [15:0] expect_dout(input int slot, input logic [obj_aw-1:0] a);
        sdram_word_t w;
        w = scramble(req_addr(slot, a));
        if (slot == 1)
            return {8'h00, w.bytes[a[0]]};
        return w.halves[0];
    endfunction

    // New random address that misses the slot's cached entry
    function automatic logic [obj_aw-1:0] rand_addr(input int slot);
        logic [obj_aw-1:0] a;
        a = $random(seed);
        if (slot == 0)
            a[obj_aw-1:char_aw] = '0;
        else if (slot == 1)
            a[obj_aw-1:main_aw] = '0;
        if (a == last_addr[slot])
            a = a ^ 18'h1;
        return a;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic drive_slot(input int slot, input logic cs, input logic [obj_aw-1:0] a);
        case (slot)
            0: begin
                char_cs   <= cs;
                char_addr <= a[char_aw-1:0];
            end
            1: begin
                main_cs   <= cs;
                main_addr <= a[main_aw-1:0];
            end
            default: begin
                obj_cs   <= cs;
                obj_addr <= a;
            end
        endcase
    endtask

    task automatic wait_ok_check(input int slot, input logic [obj_aw-1:0] a);
        int n;
        n = 0;
        while (!ok_of(slot) && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        if (!ok_of(slot)) begin
            report_error({"timeout waiting for ", slot_name(slot), "_ok"});
        end else begin
            check({slot_name(slot), "_dout"}, dout_of(slot), expect_dout(slot, a));
            last_addr[slot] = a;
        end
    endtask

    task automatic reset_test();
        @(posedge clk);
        check("sdram_req", sdram_req, 0);
        check("prog_we", prog_we, 0);
        check("char_ok", char_ok, 0);
        check("main_ok", main_ok, 0);
        check("obj_ok", obj_ok, 0);
        check("hs", hs, 0);
        check("vs", vs, 0);
        check("refresh_en", refresh_en, 1);     // Idle with nothing selected
    endtask

    task automatic cen_test();
        int n12;
        int n6;
        n12 = 0;
        n6  = 0;
        repeat (48) begin
            @(posedge clk);
            n12 += pxl2_cen;
            n6  += pxl_cen;
        end
        check("pxl2_cen pulses", n12, 12);
        check("pxl_cen pulses", n6, 6);
    endtask

    // Spans counted in cycles over one whole frame
    task automatic video_test();
        int lhbl_lo;
        int hs_hi;
        int lvbl_lo;
        int vs_hi;
        int h_steps;
        int v_steps;
        logic [pos_w-1:0] h_prev;
        logic [pos_w-1:0] v_prev;
        lhbl_lo = 0;
        hs_hi   = 0;
        lvbl_lo = 0;
        vs_hi   = 0;
        h_steps = 0;
        v_steps = 0;
        h_prev  = h;
        v_prev  = v;
        repeat (frame_cycles) begin
            @(posedge clk);
            lhbl_lo += !lhbl;
            hs_hi   += hs;
            lvbl_lo += !lvbl;
            vs_hi   += vs;
            if (h !== h_prev) begin
                h_steps++;
                check("h", h, (h_prev == hcnt_end) ? 0 : h_prev + 1);
            end
            if (v !== v_prev) begin     // Only on the line wrap
                v_steps++;
                check("v", v, (v_prev == vcnt_end) ? 0 : v_prev + 1);
            end
            h_prev = h;
            v_prev = v;
        end
        check("lhbl low", lhbl_lo, (hb_end - hb_start) * lines * cen8_div);
        check("hs high", hs_hi, (hs_end - hs_start) * lines * cen8_div);
        check("lvbl low", lvbl_lo, (vb_end - vb_start) * pixels * cen8_div);
        check("vs high", vs_hi, (vs_end - vs_start) * pixels * cen8_div);
        check("h steps", h_steps, pixels * lines);
        check("v steps", v_steps, lines);
    endtask

    task automatic download_test();
        logic [24:0] a;
        logic [7:0]  d;
        int i;
        int n;
        @(posedge clk);
        downloading <= 1'b1;
        for (i = 0; i < dwnld_bytes; i++) begin
            a = dwnld_base + i;
            d = $random(seed);
            @(posedge clk);
            ioctl_addr <= a;
            ioctl_data <= d;
            ioctl_wr   <= 1'b1;
            @(posedge clk);
            ioctl_wr <= 1'b0;
            @(posedge clk);
            check("dwnld_busy", dwnld_busy, 1);
            check("prog_we", prog_we, 1);
            check("prog_addr", prog_addr, a >> 1);
            check("prog_data", prog_data, d);
            check("prog_mask", prog_mask, a[0] ? 2'b01 : 2'b10);
            n = 0;
            while (prog_we && !sdram_ack && n < wait_limit) begin
                @(posedge clk);
                n++;
            end
            check("prog_we", prog_we, 1);   // Held through the ack cycle
            check("sdram_ack", sdram_ack, 1);
            @(posedge clk);
            check("prog_we", prog_we, 0);
        end
        downloading <= 1'b0;
        @(posedge clk);
        check("dwnld_busy", dwnld_busy, 0);
    endtask

    // Miss, then the same address again must hit with no fetch
    task automatic read_slot(input int slot, input logic [obj_aw-1:0] a);
        logic req_seen;
        @(posedge clk);
        drive_slot(slot, 1'b1, a);
        @(posedge clk);
        wait_ok_check(slot, a);
        drive_slot(slot, 1'b0, a);
        @(posedge clk);
        drive_slot(slot, 1'b1, a);
        req_seen = 1'b0;
        repeat (2) begin
            @(posedge clk);
            req_seen |= sdram_req;
        end
        check({slot_name(slot), "_ok"}, ok_of(slot), 1);
        check("sdram_req", req_seen, 0);
        check({slot_name(slot), "_dout"}, dout_of(slot), expect_dout(slot, a));
        check("refresh_en", refresh_en, 1);     // Hit leaves the port idle
        drive_slot(slot, 1'b0, a);
        repeat (2) @(posedge clk);
    endtask

    task automatic char_blank_test();
        logic [obj_aw-1:0] a;
        logic req_seen;
        int n;
        a = rand_addr(0);
        n = 0;
        @(posedge clk);
        while (lvbl && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        drive_slot(0, 1'b1, a);
        req_seen = 1'b0;
        @(posedge clk);
        while (!lvbl && n < wait_limit) begin
            req_seen |= sdram_req;
            @(posedge clk);
            n++;
        end
        if (n >= wait_limit)
            report_error("vertical blanking never came and went");
        check("sdram_req in blanking", req_seen, 0);
        wait_ok_check(0, a);
        drive_slot(0, 1'b0, a);
        repeat (2) @(posedge clk);
    endtask

    task automatic priority_test();
        logic [obj_aw-1:0]   a [3];
        logic [sdram_aw-1:0] seen [$];
        int s;
        int n;
        for (s = 0; s < 3; s++)
            a[s] = rand_addr(s);
        n = 0;
        @(posedge clk);
        while (lvbl && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        while (!lvbl && n < wait_limit) begin     // Start at the top of the active area
            @(posedge clk);
            n++;
        end
        for (s = 0; s < 3; s++)
            drive_slot(s, 1'b1, a[s]);
        @(posedge clk);
        check("refresh_en", refresh_en, 0);     // No refresh while misses are pending
        n = 0;
        while (!(char_ok && main_ok && obj_ok) && n < wait_limit) begin
            @(posedge clk);
            n++;
            if (sdram_req && sdram_ack)
                seen.push_back(sdram_addr);
        end
        check("fetch count", seen.size(), 3);
        for (s = 0; s < 3 && s < seen.size(); s++)
            check("sdram_addr", seen[s], req_addr(s, a[s]));
        for (s = 0; s < 3; s++) begin
            check({slot_name(s), "_dout"}, dout_of(s), expect_dout(s, a[s]));
            drive_slot(s, 1'b0, a[s]);
        end
        repeat (2) @(posedge clk);
    endtask

    initial begin
        int i;
        int s;
        for (i = 0; i < 64; i++)
            lat_tab[i] = 1 + ($unsigned($random(seed)) % 4);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        reset_test();
        cen_test();
        video_test();
        download_test();
        for (s = 0; s < 3; s++)
            repeat (reads_per_slot) read_slot(s, rand_addr(s));
        char_blank_test();
        priority_test();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
